//--- control_supervisor.f
design/supervisor_timing_pkg.sv
design/supervisor_codes_pkg.sv
design/reset_pulse_stretcher.sv
design/led_glow.sv
design/pll_lock_monitor.sv
design/status_indicator.sv
design/control_supervisor.sv
sim/supervisor_checker.sv
sim/tb_control_supervisor.sv

//--- design/control_supervisor.sv
`timescale 1ns/1ps
`default_nettype none

module control_supervisor (
    input  logic       control_clock,
    input  logic       reset_dc,
    input  logic       console_reset_request,
    input  logic       optical_reset_request,
    input  logic [1:0] led_mode,
    input  logic       capture_pll_locked,
    input  logic       hdmi_pll_locked,
    input  logic       resync_active,
    input  logic       force_generate_active,
    input  logic       hdmi_tx_ready,
    output logic       console_reset_drive_low,
    output logic       optical_reset_drive_low,
    output logic       pll_reconfig_reset,
    output logic       pll_ready,
    output logic       status_led_level,
    output logic       status_led_enable
);

    logic slow_glow;
    logic fast_glow;

    ////////////////////////////////////////////////////////////
    // console and optical drive reset lines
    ////////////////////////////////////////////////////////////

    reset_pulse_stretcher u_console_reset (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .request       (console_reset_request),
        .drive_low     (console_reset_drive_low)
    );

    reset_pulse_stretcher u_optical_reset (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .request       (optical_reset_request),
        .drive_low     (optical_reset_drive_low)
    );

    // pll supervision
    pll_lock_monitor u_pll_lock_monitor (
        .control_clock      (control_clock),
        .reset_dc           (reset_dc),
        .capture_pll_locked (capture_pll_locked),
        .hdmi_pll_locked    (hdmi_pll_locked),
        .pll_ready          (pll_ready),
        .pll_reconfig_reset (pll_reconfig_reset)
    );

    ////////////////////////////////////////////////////////////
    // status LED
    ////////////////////////////////////////////////////////////

    led_glow #(
        .glow_bit (supervisor_timing_pkg::SLOW_GLOW_BIT)
    ) u_slow_glow (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .glow          (slow_glow)
    );

    led_glow #(
        .glow_bit (supervisor_timing_pkg::FAST_GLOW_BIT)
    ) u_fast_glow (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .glow          (fast_glow)
    );

    status_indicator u_status_indicator (
        .control_clock           (control_clock),
        .reset_dc                (reset_dc),
        .led_mode                (led_mode),
        .pll_ready               (pll_ready),
        .resync_active           (resync_active),
        .force_generate_active   (force_generate_active),
        .hdmi_tx_ready           (hdmi_tx_ready),
        .console_reset_drive_low (console_reset_drive_low),
        .optical_reset_drive_low (optical_reset_drive_low),
        .slow_glow               (slow_glow),
        .fast_glow               (fast_glow),
        .status_led_level        (status_led_level),
        .status_led_enable       (status_led_enable)
    );

endmodule

`default_nettype wire

//--- design/led_glow.sv
`timescale 1ns/1ps
`default_nettype none

module led_glow #(
    parameter int glow_bit = 12
) (
    input  logic control_clock,
    input  logic reset_dc,
    output logic glow
);

    logic [glow_bit:0] glow_count;
    logic [3:0]        ramp;
    logic [3:0]        brightness;

    // four bits under the top bit set the duty
    assign ramp = glow_count[glow_bit-1 -: 4];

    // second half of the period runs the ramp backwards
    assign brightness = glow_count[glow_bit] ? ~ramp : ramp;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            glow_count <= '0;
            glow       <= 1'b0;
        end else begin
            glow_count <= glow_count + 1'b1;
            // pwm against the low four bits
            glow       <= (glow_count[3:0] < brightness);
        end
    end

endmodule

`default_nettype wire

//--- design/pll_lock_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module pll_lock_monitor (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic capture_pll_locked,
    input  logic hdmi_pll_locked,
    output logic pll_ready,
    output logic pll_reconfig_reset
);

    logic [supervisor_timing_pkg::SYNC_STAGES-1:0] capture_sync;
    logic [supervisor_timing_pkg::SYNC_STAGES-1:0] hdmi_sync;
    logic capture_locked;
    logic hdmi_locked;
    logic capture_locked_prev;
    logic hdmi_locked_prev;
    logic lock_lost;

    assign capture_locked = capture_sync[supervisor_timing_pkg::SYNC_STAGES-1];
    assign hdmi_locked    = hdmi_sync[supervisor_timing_pkg::SYNC_STAGES-1];

    // falling edge on either synchronized lock
    assign lock_lost = (capture_locked_prev && !capture_locked) ||
                       (hdmi_locked_prev && !hdmi_locked);

    ////////////////////////////////////////////////////////////
    // lock synchronizers and loss detect
    ////////////////////////////////////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            capture_sync        <= '0;
            hdmi_sync           <= '0;
            capture_locked_prev <= 1'b0;
            hdmi_locked_prev    <= 1'b0;
            pll_ready           <= 1'b0;
            pll_reconfig_reset  <= 1'b0;
        end else begin
            capture_sync <= {capture_sync[supervisor_timing_pkg::SYNC_STAGES-2:0],
                             capture_pll_locked};
            hdmi_sync    <= {hdmi_sync[supervisor_timing_pkg::SYNC_STAGES-2:0],
                             hdmi_pll_locked};
            capture_locked_prev <= capture_locked;
            hdmi_locked_prev    <= hdmi_locked;
            pll_ready           <= capture_locked && hdmi_locked;
            pll_reconfig_reset  <= lock_lost;
        end
    end

    // one reconfiguration request per loss of lock
    a_single_cycle_pulse : assert property (
        @(posedge control_clock) disable iff (reset_dc)
        pll_reconfig_reset |=> !pll_reconfig_reset
    );

endmodule

`default_nettype wire

//--- design/reset_pulse_stretcher.sv
`timescale 1ns/1ps
`default_nettype none

module reset_pulse_stretcher (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic request,
    output logic drive_low
);

    typedef logic [supervisor_timing_pkg::HOLD_COUNT_WIDTH-1:0] hold_count_t;

    hold_count_t hold_count;
    logic        hold_done;

    assign hold_done = (hold_count == hold_count_t'(supervisor_timing_pkg::RESET_HOLD_CYCLES));

    // counter parks at the hold count and the line stays released
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            hold_count <= hold_count_t'(supervisor_timing_pkg::RESET_HOLD_CYCLES);
            drive_low  <= 1'b0;
        end else if (request) begin
            // restart the hold on every request cycle
            hold_count <= '0;
            drive_low  <= 1'b1;
        end else if (hold_done) begin
            drive_low  <= 1'b0;
        end else begin
            hold_count <= hold_count + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // the line is only released once the full hold has elapsed
    a_release_after_hold : assert property (
        @(posedge control_clock) disable iff (reset_dc)
        ($fell(drive_low) && !$past(reset_dc))
            |-> $past(hold_count) == hold_count_t'(supervisor_timing_pkg::RESET_HOLD_CYCLES)
    );

endmodule

`default_nettype wire

//--- design/status_indicator.sv
`timescale 1ns/1ps
`default_nettype none

module status_indicator (
    input  logic       control_clock,
    input  logic       reset_dc,
    input  logic [1:0] led_mode,
    input  logic       pll_ready,
    input  logic       resync_active,
    input  logic       force_generate_active,
    input  logic       hdmi_tx_ready,
    input  logic       console_reset_drive_low,
    input  logic       optical_reset_drive_low,
    input  logic       slow_glow,
    input  logic       fast_glow,
    output logic       status_led_level,
    output logic       status_led_enable
);

    logic [supervisor_timing_pkg::SYNC_STAGES-1:0] resync_sync;
    logic [supervisor_timing_pkg::SYNC_STAGES-1:0] force_sync;
    logic [supervisor_timing_pkg::BLINK_BIT:0]     blink_count;
    logic resync_seen;
    logic force_seen;
    logic mirror_drive;
    logic next_level;
    logic next_enable;

    supervisor_codes_pkg::led_mode_e        mode;
    supervisor_codes_pkg::indicator_state_e ind_state;

    assign mode        = supervisor_codes_pkg::led_mode_e'(led_mode);
    assign resync_seen = resync_sync[supervisor_timing_pkg::SYNC_STAGES-1];
    assign force_seen  = force_sync[supervisor_timing_pkg::SYNC_STAGES-1];

    ////////////////////////////////////////////////////////////
    // state selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        ind_state    = supervisor_codes_pkg::IND_WAITING;
        mirror_drive = 1'b0;
        case (mode)
            supervisor_codes_pkg::LED_MODE_STATUS: begin
                // highest priority first
                if (!pll_ready) begin
                    ind_state = supervisor_codes_pkg::IND_PLL_DOWN;
                end else if (resync_seen) begin
                    ind_state = supervisor_codes_pkg::IND_RESYNC;
                end else if (force_seen) begin
                    ind_state = supervisor_codes_pkg::IND_FORCE_GENERATE;
                end else if (hdmi_tx_ready) begin
                    ind_state = supervisor_codes_pkg::IND_HDMI_READY;
                end
            end
            supervisor_codes_pkg::LED_MODE_MIRROR_CONSOLE: begin
                ind_state    = supervisor_codes_pkg::IND_MIRROR;
                mirror_drive = console_reset_drive_low;
            end
            default: begin
                // codes 1 and 3 both mirror the optical drive reset
                ind_state    = supervisor_codes_pkg::IND_MIRROR;
                mirror_drive = optical_reset_drive_low;
            end
        endcase
    end

    // led is active low so a high level means off
    always_comb begin
        next_level  = 1'b1;
        next_enable = 1'b1;
        case (ind_state)
            supervisor_codes_pkg::IND_PLL_DOWN:       next_level = 1'b1;
            supervisor_codes_pkg::IND_RESYNC:         next_level = ~fast_glow;
            supervisor_codes_pkg::IND_FORCE_GENERATE: begin
                next_level = blink_count[supervisor_timing_pkg::BLINK_BIT] ? ~fast_glow : 1'b1;
            end
            supervisor_codes_pkg::IND_HDMI_READY:     next_level = 1'b0;
            supervisor_codes_pkg::IND_WAITING:        next_level = ~slow_glow;
            supervisor_codes_pkg::IND_MIRROR: begin
                // open-drain copy of the mirrored reset line
                next_level  = 1'b0;
                next_enable = mirror_drive;
            end
            default: next_level = 1'b1;
        endcase
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            resync_sync       <= '0;
            force_sync        <= '0;
            blink_count       <= '0;
            status_led_level  <= 1'b1;
            status_led_enable <= 1'b1;
        end else begin
            resync_sync <= {resync_sync[supervisor_timing_pkg::SYNC_STAGES-2:0], resync_active};
            force_sync  <= {force_sync[supervisor_timing_pkg::SYNC_STAGES-2:0],
                            force_generate_active};
            blink_count       <= blink_count + 1'b1;
            status_led_level  <= next_level;
            status_led_enable <= next_enable;
        end
    end

    // a mirror mode never lets the pin float high through the driver
    a_mirror_level_low : assert property (
        @(posedge control_clock) disable iff (reset_dc)
        (mode != supervisor_codes_pkg::LED_MODE_STATUS)
            |=> !(status_led_level && status_led_enable)
    );

endmodule

`default_nettype wire

//--- design/supervisor_codes_pkg.sv
`default_nettype none

package supervisor_codes_pkg;

    // LED mode opcode as written by the configuration master
    // code 3 is decoded like LED_MODE_MIRROR_OPTICAL
    typedef enum logic [1:0] {
        LED_MODE_STATUS         = 2'd0,
        LED_MODE_MIRROR_OPTICAL = 2'd1,
        LED_MODE_MIRROR_CONSOLE = 2'd2
    } led_mode_e;

    // what the status LED is currently showing
    typedef enum logic [2:0] {
        IND_PLL_DOWN,
        IND_RESYNC,
        IND_FORCE_GENERATE,
        IND_HDMI_READY,
        IND_WAITING,
        IND_MIRROR
    } indicator_state_e;

endpackage

`default_nettype wire

//--- design/supervisor_timing_pkg.sv
`default_nettype none

package supervisor_timing_pkg;

    ////////////////////////////////////////////////////////////
    // reset line hold
    ////////////////////////////////////////////////////////////

    // cycles a reset line stays low once its request ends
    // 32 million cycles on the board
    localparam int unsigned RESET_HOLD_CYCLES = 40;
    localparam int unsigned HOLD_COUNT_WIDTH  = $clog2(RESET_HOLD_CYCLES + 1);

    ////////////////////////////////////////////////////////////
    // LED timing
    ////////////////////////////////////////////////////////////

    // top counter bit of each breathing glow
    localparam int unsigned SLOW_GLOW_BIT = 12;
    localparam int unsigned FAST_GLOW_BIT = 9;

    // indicator counter bit that gates the force-generate blink
    localparam int unsigned BLINK_BIT = 10;

    // flops in each synchronizer chain
    localparam int unsigned SYNC_STAGES = 2;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f control_supervisor.f \
    --top-module tb_control_supervisor \
    --Mdir obj_dir -o tb_control_supervisor

output="$(./obj_dir/tb_control_supervisor)"
echo "$output"

grep -qx "ALL TESTS PASSED" <<< "$output"

//--- sim/supervisor_checker.sv
`timescale 1ns/1ps
`default_nettype none

module supervisor_checker (
    input  logic       control_clock,
    input  logic       check_enable,
    input  logic       console_reset_drive_low,
    input  logic       optical_reset_drive_low,
    input  logic       pll_reconfig_reset,
    input  logic       pll_ready,
    input  logic       status_led_level,
    input  logic       status_led_enable,
    input  logic       expected_console_low,
    input  logic       expected_optical_low,
    input  logic       expected_reconfig,
    input  logic       expected_ready,
    input  logic       expected_level,
    input  logic       expected_enable,
    input  logic [1:0] expected_level_kind,
    output int         error_count,
    output int         check_count
);

    localparam int FAST_LIMIT = 2 ** (supervisor_timing_pkg::FAST_GLOW_BIT + 1);
    localparam int SLOW_LIMIT = 2 ** (supervisor_timing_pkg::SLOW_GLOW_BIT + 1);

    int errors = 0;
    int checks = 0;
    int stale_cycles = 0;
    logic [1:0] last_kind = 2'd0;
    logic last_level = 1'b0;

    assign error_count = errors;
    assign check_count = checks;

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s expected 0x%h actual 0x%h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    always @(posedge control_clock) begin
        if (check_enable) begin
            compare_bit("console_reset_drive_low", expected_console_low,
                        console_reset_drive_low);
            compare_bit("optical_reset_drive_low", expected_optical_low,
                        optical_reset_drive_low);
            compare_bit("pll_ready", expected_ready, pll_ready);
            compare_bit("status_led_enable", expected_enable, status_led_enable);
            if (expected_reconfig && pll_reconfig_reset !== 1'b1) begin
                errors++;
                $display("missing pll_reconfig_reset pulse after a loss of lock at %0t", $time);
            end else begin
                compare_bit("pll_reconfig_reset", expected_reconfig, pll_reconfig_reset);
            end
            if (expected_level_kind == 2'd0) begin
                compare_bit("status_led_level", expected_level, status_led_level);
            end
            // glowing level has to move within one glow period
            if (expected_level_kind == 2'd1 || expected_level_kind == 2'd2) begin
                if (expected_level_kind != last_kind || status_led_level != last_level) begin
                    stale_cycles = 0;
                end else begin
                    stale_cycles++;
                end
                if (stale_cycles > ((expected_level_kind == 2'd1) ? FAST_LIMIT : SLOW_LIMIT)) begin
                    errors++;
                    stale_cycles = 0;
                    $display("status_led_level did not change within a glow period at %0t",
                             $time);
                end
            end
            last_kind  = expected_level_kind;
            last_level = status_led_level;
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_control_supervisor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_control_supervisor;

    localparam int HOLD = supervisor_timing_pkg::RESET_HOLD_CYCLES;
    localparam int SYNC = supervisor_timing_pkg::SYNC_STAGES;
    localparam int BLINK_BIT = supervisor_timing_pkg::BLINK_BIT;
    localparam int FAST_PERIOD = 2 ** (supervisor_timing_pkg::FAST_GLOW_BIT + 1);
    localparam int SLOW_PERIOD = 2 ** (supervisor_timing_pkg::SLOW_GLOW_BIT + 1);
    localparam int BLINK_PERIOD = 2 ** (BLINK_BIT + 1);
    localparam int HOLD_TESTS = 10;
    localparam int HOLD_TEST_CYCLES = HOLD_TESTS * (8 + 60) + 3 * (HOLD + 10);
    localparam int LED_TEST_CYCLES = 3 * FAST_PERIOD / 2 + 5 * SLOW_PERIOD / 4 + 2 * BLINK_PERIOD;
    localparam int MIRROR_TEST_CYCLES = 3 * (HOLD + 20);
    localparam int TIMEOUT_CYCLES = 16 + HOLD_TEST_CYCLES + 200 + LED_TEST_CYCLES
                                    + MIRROR_TEST_CYCLES + 1000;

    // how the checker treats status_led_level
    localparam logic [1:0] LEVEL_EXACT = 2'd0;
    localparam logic [1:0] LEVEL_FAST  = 2'd1;
    localparam logic [1:0] LEVEL_SLOW  = 2'd2;
    localparam logic [1:0] LEVEL_ANY   = 2'd3;

    logic control_clock = 1'b0;
    logic reset_dc;
    logic console_reset_request;
    logic optical_reset_request;
    logic [1:0] led_mode;
    logic capture_pll_locked;
    logic hdmi_pll_locked;
    logic resync_active;
    logic force_generate_active;
    logic hdmi_tx_ready;
    logic console_reset_drive_low;
    logic optical_reset_drive_low;
    logic pll_reconfig_reset;
    logic pll_ready;
    logic status_led_level;
    logic status_led_enable;
    logic check_enable;
    logic [31:0] lcg_state;
    int cycle_count = 0;
    int error_count;
    int check_count;

    // reference model state
    int console_age;
    int optical_age;
    logic [SYNC+1:0] capture_hist;
    logic [SYNC+1:0] hdmi_hist;
    logic [SYNC-1:0] resync_hist;
    logic [SYNC-1:0] force_hist;
    logic [BLINK_BIT:0] blink_count;
    logic [3:0] expected_led;
    logic expected_console_low;
    logic expected_optical_low;
    logic expected_ready;
    logic expected_reconfig;

    always #50 control_clock = ~control_clock;

    control_supervisor u_control_supervisor (.*);

    supervisor_checker u_supervisor_checker (
        .control_clock           (control_clock),
        .check_enable            (check_enable),
        .console_reset_drive_low (console_reset_drive_low),
        .optical_reset_drive_low (optical_reset_drive_low),
        .pll_reconfig_reset      (pll_reconfig_reset),
        .pll_ready               (pll_ready),
        .status_led_level        (status_led_level),
        .status_led_enable       (status_led_enable),
        .expected_console_low    (expected_console_low),
        .expected_optical_low    (expected_optical_low),
        .expected_reconfig       (expected_reconfig),
        .expected_ready          (expected_ready),
        .expected_level          (expected_led[1]),
        .expected_enable         (expected_led[0]),
        .expected_level_kind     (expected_led[3:2]),
        .error_count             (error_count),
        .check_count             (check_count)
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // line held for HOLD cycles after the last request cycle
    assign expected_console_low = (console_age <= HOLD);
    assign expected_optical_low = (optical_age <= HOLD);
    assign expected_ready       = capture_hist[SYNC] && hdmi_hist[SYNC];
    assign expected_reconfig    = (capture_hist[SYNC+1] && !capture_hist[SYNC]) ||
                                  (hdmi_hist[SYNC+1] && !hdmi_hist[SYNC]);

    // next LED value as {level kind, level, enable}
    // level high is off
    function automatic logic [3:0] led_reference(input logic [1:0] mode, input logic ready,
                                                 input logic resync, input logic force_on,
                                                 input logic hdmi_ready, input logic console_low,
                                                 input logic optical_low, input logic blink);
        if (mode == 2'd2) begin
            return {LEVEL_EXACT, 1'b0, console_low};
        end else if (mode != 2'd0) begin
            return {LEVEL_EXACT, 1'b0, optical_low};
        end else if (!ready) begin
            return {LEVEL_EXACT, 1'b1, 1'b1};
        end else if (resync) begin
            return {LEVEL_FAST, 1'b1, 1'b1};
        end else if (force_on) begin
            return blink ? {LEVEL_ANY, 1'b1, 1'b1} : {LEVEL_EXACT, 1'b1, 1'b1};
        end else if (hdmi_ready) begin
            return {LEVEL_EXACT, 1'b0, 1'b1};
        end
        return {LEVEL_SLOW, 1'b1, 1'b1};
    endfunction

    always @(posedge control_clock) begin
        if (reset_dc) begin
            console_age  <= HOLD + 1;
            optical_age  <= HOLD + 1;
            capture_hist <= '0;
            hdmi_hist    <= '0;
            resync_hist  <= '0;
            force_hist   <= '0;
            blink_count  <= '0;
            expected_led <= {LEVEL_EXACT, 1'b1, 1'b1};
        end else begin
            console_age  <= console_reset_request ? 0 : console_age + int'(console_age <= HOLD);
            optical_age  <= optical_reset_request ? 0 : optical_age + int'(optical_age <= HOLD);
            capture_hist <= {capture_hist[SYNC:0], capture_pll_locked};
            hdmi_hist    <= {hdmi_hist[SYNC:0], hdmi_pll_locked};
            resync_hist  <= {resync_hist[SYNC-2:0], resync_active};
            force_hist   <= {force_hist[SYNC-2:0], force_generate_active};
            blink_count  <= blink_count + 1'b1;
            expected_led <= led_reference(led_mode, expected_ready, resync_hist[SYNC-1],
                                          force_hist[SYNC-1], hdmi_tx_ready,
                                          expected_console_low, expected_optical_low,
                                          blink_count[BLINK_BIT]);
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic wait_cycles(input int count);
        repeat (count) @(negedge control_clock);
    endtask

    // lcg draw in the range 0 to span-1
    function automatic int draw(input int span);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]) % span;
    endfunction

    // which selects 0 console, 1 optical or 2 both
    task automatic request_reset(input int which, input int length);
        console_reset_request = (which != 1);
        optical_reset_request = (which != 0);
        wait_cycles(length);
        console_reset_request = 1'b0;
        optical_reset_request = 1'b0;
    endtask

    always @(posedge control_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d  errors: %0d", check_count, error_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int which;
        int length;
        int gap;
        lcg_state = 32'd19258;
        reset_dc = 1'b1;
        console_reset_request = 1'b0;
        optical_reset_request = 1'b0;
        led_mode = 2'd0;
        capture_pll_locked = 1'b0;
        hdmi_pll_locked = 1'b0;
        resync_active = 1'b0;
        force_generate_active = 1'b0;
        hdmi_tx_ready = 1'b0;
        check_enable = 1'b0;
        wait_cycles(2);
        check_enable = 1'b1;
        wait_cycles(14);
        reset_dc = 1'b0;
        wait_cycles(4);
        // reset holds with short gaps that retrigger during the hold
        for (int i = 0; i < HOLD_TESTS; i++) begin
            which = draw(3);
            length = draw(8);
            gap = draw(56);
            request_reset(which, length + 1);
            wait_cycles(gap + 5);
        end
        request_reset(0, 2);
        wait_cycles(HOLD / 2);
        request_reset(0, 1);
        wait_cycles(HOLD + 10);
        // lock loss on each PLL in turn
        capture_pll_locked = 1'b1;
        hdmi_pll_locked = 1'b1;
        wait_cycles(10);
        capture_pll_locked = 1'b0;
        wait_cycles(10);
        capture_pll_locked = 1'b1;
        wait_cycles(10);
        hdmi_pll_locked = 1'b0;
        wait_cycles(10);
        hdmi_pll_locked = 1'b1;
        wait_cycles(10);
        // status LED priorities
        hdmi_tx_ready = 1'b1;
        wait_cycles(10);
        resync_active = 1'b1;
        wait_cycles(3 * FAST_PERIOD / 2);
        resync_active = 1'b0;
        hdmi_tx_ready = 1'b0;
        wait_cycles(5 * SLOW_PERIOD / 4);
        force_generate_active = 1'b1;
        wait_cycles(2 * BLINK_PERIOD);
        force_generate_active = 1'b0;
        // mirror modes
        led_mode = 2'd2;
        request_reset(0, 3);
        wait_cycles(HOLD + 10);
        led_mode = 2'd1;
        request_reset(1, 3);
        wait_cycles(HOLD + 10);
        led_mode = 2'd3;
        request_reset(1, 3);
        wait_cycles(HOLD + 10);
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
